/* Bender.yml */
package:
  name: spi_host

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/spi_host_reg_pkg.sv
      - design/spi_host_pkg.sv
      - design/reg_bus_if.sv
      - design/spi_host_fifo.sv
      - design/spi_host_window.sv
      - design/spi_host_regs.sv
      - design/spi_host_core.sv
      - design/spi_host_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tb_spi_host.sv

/* build.f */
+incdir+design
design/spi_host_reg_pkg.sv
design/spi_host_pkg.sv
design/reg_bus_if.sv
design/spi_host_fifo.sv
design/spi_host_window.sv
design/spi_host_regs.sv
design/spi_host_core.sv
design/spi_host_top.sv
sim/tb_spi_host.sv

/* design/reg_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_host_macros.svh"

// Single-cycle register bus, response valid in the request cycle
interface reg_bus_if;

  logic [`SPI_HOST_AW-1:0]   addr;
  logic                      write;
  logic [`SPI_HOST_DW-1:0]   wdata;
  logic [`SPI_HOST_DW/8-1:0] wstrb;
  logic                      valid;
  logic [`SPI_HOST_DW-1:0]   rdata;
  logic                      error;

  // Requester side
  modport master (
    output addr, write, wdata, wstrb, valid,
    input  rdata, error
  );

  // Responder side
  modport slave (
    input  addr, write, wdata, wstrb, valid,
    output rdata, error
  );

endinterface

`default_nettype wire

/* design/spi_host_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_host_macros.svh"

module spi_host_core (
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,
  input  wire logic [7:0]              clkdiv_i,
  input  wire logic                    cmd_valid_i,
  input  wire spi_host_pkg::cmd_t      cmd_i,
  output logic                         busy_o,
  output logic                         tx_pop_o,
  input  wire logic [`SPI_HOST_DW-1:0] tx_data_i,
  input  wire logic                    tx_empty_i,
  output logic                         rx_push_o,
  output logic [`SPI_HOST_DW-1:0]      rx_data_o,
  input  wire logic                    rx_full_i,
  output logic                         rx_lost_o,
  output logic                         spi_sck_o,
  output logic                         spi_cs_n_o,
  output logic                         spi_sdo_o,
  input  wire logic                    spi_sdi_i
);

  localparam int BW = $clog2(`SPI_HOST_DW);

  spi_host_pkg::core_state_e state_q;
  spi_host_pkg::core_state_e state_d;
  spi_host_pkg::cmd_dir_e    dir_q;
  logic [7:0]                words_q;
  logic [7:0]                div_q;
  logic [BW-1:0]             bit_q;
  logic [`SPI_HOST_DW-1:0]   shreg_q;
  logic                      sdi_q;
  logic                      tick;
  logic                      sck_rise;
  logic                      sck_fall;
  logic                      last_bit;

  // Half-period tick, >= guards against clkdiv shrinking mid-count
  assign tick     = (state_q == spi_host_pkg::ST_SHIFT) && (div_q >= clkdiv_i);
  assign sck_rise = tick & ~spi_sck_o;
  assign sck_fall = tick & spi_sck_o;
  assign last_bit = sck_fall && (bit_q == BW'(`SPI_HOST_DW - 1));

  always_comb begin
    state_d = state_q;
    case (state_q)
      spi_host_pkg::ST_IDLE:  if (cmd_valid_i) state_d = spi_host_pkg::ST_LOAD;
      spi_host_pkg::ST_LOAD:  state_d = spi_host_pkg::ST_SHIFT;
      spi_host_pkg::ST_SHIFT: if (last_bit) state_d = spi_host_pkg::ST_STORE;
      // One word per pass until the count runs out
      spi_host_pkg::ST_STORE: begin
        state_d = (words_q == '0) ? spi_host_pkg::ST_DONE : spi_host_pkg::ST_LOAD;
      end
      spi_host_pkg::ST_DONE:  state_d = spi_host_pkg::ST_IDLE;
      default:                state_d = spi_host_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= spi_host_pkg::ST_IDLE;
      dir_q      <= spi_host_pkg::DIR_DUPLEX;
      words_q    <= '0;
      div_q      <= '0;
      bit_q      <= '0;
      spi_sck_o  <= 1'b0;
      spi_cs_n_o <= 1'b1;
    end else begin
      state_q <= state_d;
      if ((state_q == spi_host_pkg::ST_IDLE) && cmd_valid_i) begin
        dir_q   <= cmd_i.dir;
        words_q <= cmd_i.len;
      end else if ((state_q == spi_host_pkg::ST_STORE) && (words_q != '0)) begin
        words_q <= words_q - 1'b1;
      end
      // CS low from first load, high as busy drops
      if (state_q == spi_host_pkg::ST_LOAD) begin
        spi_cs_n_o <= 1'b0;
      end else if (state_q == spi_host_pkg::ST_DONE) begin
        spi_cs_n_o <= 1'b1;
      end
      // Divider runs only while shifting
      if ((state_q != spi_host_pkg::ST_SHIFT) || tick) begin
        div_q <= '0;
      end else begin
        div_q <= div_q + 1'b1;
      end
      if (tick) begin
        spi_sck_o <= ~spi_sck_o;
      end
      // Bit count advances on falling SCK
      if (state_q == spi_host_pkg::ST_LOAD) begin
        bit_q <= '0;
      end else if (sck_fall) begin
        bit_q <= bit_q + 1'b1;
      end
    end
  end

  // Mode 0 sample on rise, shift on fall
  always_ff @(posedge clk_i) begin
    if (state_q == spi_host_pkg::ST_LOAD) begin
      // Empty TX FIFO sends zeros
      shreg_q <= tx_empty_i ? '0 : tx_data_i;
    end else if (sck_fall) begin
      shreg_q <= {shreg_q[`SPI_HOST_DW-2:0], sdi_q};
    end
    if (sck_rise) begin
      sdi_q <= spi_sdi_i;
    end
  end

  assign busy_o    = (state_q != spi_host_pkg::ST_IDLE);
  assign tx_pop_o  = (state_q == spi_host_pkg::ST_LOAD);
  // Received word only kept in duplex mode
  assign rx_push_o = (state_q == spi_host_pkg::ST_STORE) && (dir_q == spi_host_pkg::DIR_DUPLEX);
  assign rx_lost_o = rx_push_o & rx_full_i;
  assign rx_data_o = shreg_q;
  // SDO parked low outside a transfer
  assign spi_sdo_o = ~spi_cs_n_o & shreg_q[`SPI_HOST_DW-1];

endmodule

`default_nettype wire

/* design/spi_host_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_host_macros.svh"

module spi_host_fifo #(
  parameter int Depth = 4
) (
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,
  input  wire logic                    push_i,
  input  wire logic [`SPI_HOST_DW-1:0] wdata_i,
  input  wire logic                    pop_i,
  output logic [`SPI_HOST_DW-1:0]      rdata_o,
  output logic                         full_o,
  output logic                         empty_o,
  output logic [`SPI_HOST_LW-1:0]      level_o
);

  localparam int PW = (Depth > 1) ? $clog2(Depth) : 1;

  logic [`SPI_HOST_DW-1:0] mem [Depth];
  logic [PW-1:0]           wptr_q;
  logic [PW-1:0]           rptr_q;
  logic                    do_push;
  logic                    do_pop;

  assign full_o  = (level_o == `SPI_HOST_LW'(Depth));
  assign empty_o = (level_o == '0);

  // Full drops pushes, empty drops pops
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Head word visible without a read cycle
  assign rdata_o = mem[rptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_o <= '0;
    end else begin
      // Pointers wrap at Depth
      if (do_push) begin
        wptr_q <= (wptr_q == PW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= (rptr_q == PW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      if (do_push & ~do_pop) begin
        level_o <= level_o + 1'b1;
      end else if (do_pop & ~do_push) begin
        level_o <= level_o - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wptr_q] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

/* design/spi_host_macros.svh */
`ifndef SPI_HOST_MACROS_SVH
`define SPI_HOST_MACROS_SVH

// Bus word and serial word width
`define SPI_HOST_DW 32

// Register address width covering both the local and window regions
`define SPI_HOST_AW 5

// Entries in each data FIFO
`define SPI_HOST_TX_DEPTH 4
`define SPI_HOST_RX_DEPTH 4

// Level counter width, wide enough to hold a full FIFO
`define SPI_HOST_LW 3

`endif

/* design/spi_host_pkg.sv */
`default_nettype none

package spi_host_pkg;

  // Transfer direction
  typedef enum logic {
    DIR_DUPLEX  = 1'b0,
    DIR_TX_ONLY = 1'b1
  } cmd_dir_e;

  // COMMAND payload, len holds word count minus one
  typedef struct packed {
    cmd_dir_e   dir;
    logic [7:0] len;
  } cmd_t;

  // Serial engine states
  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0,
    ST_LOAD  = 3'd1,
    ST_SHIFT = 3'd2,
    ST_STORE = 3'd3,
    ST_DONE  = 3'd4
  } core_state_e;

endpackage

`default_nettype wire

/* design/spi_host_reg_pkg.sv */
`default_nettype none

`include "spi_host_macros.svh"

package spi_host_reg_pkg;

  // Local register offsets, address bit 4 clear
  localparam logic [`SPI_HOST_AW-1:0] CONTROL_OFFSET = 5'h00;
  localparam logic [`SPI_HOST_AW-1:0] STATUS_OFFSET  = 5'h04;
  localparam logic [`SPI_HOST_AW-1:0] COMMAND_OFFSET = 5'h08;

  // Data window offsets, address bit 4 set
  localparam logic [`SPI_HOST_AW-1:0] TXDATA_OFFSET  = 5'h10;
  localparam logic [`SPI_HOST_AW-1:0] RXDATA_OFFSET  = 5'h14;

  // CONTROL layout
  typedef struct packed {
    logic [22:0] rsvd;
    logic [7:0]  clkdiv;
    logic        enable;
  } control_t;

  // STATUS layout, flags at bits 3 and 4 are write 1 to clear
  typedef struct packed {
    logic [20:0] rsvd;
    logic [2:0]  rx_level;
    logic [2:0]  tx_level;
    logic        underflow;
    logic        overflow;
    logic        rx_empty;
    logic        tx_full;
    logic        busy;
  } status_t;

endpackage

`default_nettype wire

/* design/spi_host_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_host_macros.svh"

module spi_host_regs (
  input  wire logic                          clk_i,
  input  wire logic                          rst_n_i,
  input  wire logic [`SPI_HOST_AW-1:0]       reg_addr_i,
  input  wire logic                          reg_write_i,
  input  wire logic [`SPI_HOST_DW-1:0]       reg_wdata_i,
  input  wire logic [`SPI_HOST_DW/8-1:0]     reg_wstrb_i,
  input  wire logic                          reg_valid_i,
  output logic      [`SPI_HOST_DW-1:0]       reg_rdata_o,
  output logic                               reg_error_o,
  reg_bus_if.master                          win_bus,
  output logic      [7:0]                    clkdiv_o,
  output logic                               cmd_valid_o,
  output spi_host_pkg::cmd_t                 cmd_o,
  input  wire logic                          busy_i,
  input  wire logic                          rx_lost_i,
  input  wire logic                          ovf_pulse_i,
  input  wire logic                          udf_pulse_i,
  input  wire logic                          tx_full_i,
  input  wire logic                          rx_empty_i,
  input  wire logic [`SPI_HOST_LW-1:0]       tx_level_i,
  input  wire logic [`SPI_HOST_LW-1:0]       rx_level_i
);

  spi_host_reg_pkg::control_t control_q;
  spi_host_reg_pkg::status_t  status;
  spi_host_reg_pkg::status_t  stat_wr;
  spi_host_pkg::cmd_t         cmd_wr;
  logic                       ovf_q;
  logic                       udf_q;
  logic                       win_sel;
  logic                       loc_valid;
  logic                       ctrl_we;
  logic                       stat_we;
  logic                       cmd_we;
  logic                       cmd_ok;
  logic [`SPI_HOST_DW-1:0]    loc_rdata;
  logic                       loc_error;

  // Address bit 4 selects the data window
  assign win_sel   = reg_addr_i[4];
  assign loc_valid = reg_valid_i & ~win_sel;

  // Window requests pass through untouched
  assign win_bus.addr  = reg_addr_i;
  assign win_bus.write = reg_write_i;
  assign win_bus.wdata = reg_wdata_i;
  assign win_bus.wstrb = reg_wstrb_i;
  assign win_bus.valid = reg_valid_i & win_sel;

  assign ctrl_we = loc_valid & reg_write_i & (reg_addr_i == spi_host_reg_pkg::CONTROL_OFFSET);
  assign stat_we = loc_valid & reg_write_i & (reg_addr_i == spi_host_reg_pkg::STATUS_OFFSET);
  assign cmd_we  = loc_valid & reg_write_i & (reg_addr_i == spi_host_reg_pkg::COMMAND_OFFSET);

  // A pending start counts as busy so two commands cannot overlap
  assign cmd_ok  = control_q.enable & ~busy_i & ~cmd_valid_o;
  assign stat_wr = reg_wdata_i;
  assign cmd_wr  = spi_host_pkg::cmd_t'(reg_wdata_i[8:0]);

  // Flags also show pulses not yet folded into the sticky bits
  always_comb begin
    status           = '0;
    status.busy      = busy_i;
    status.tx_full   = tx_full_i;
    status.rx_empty  = rx_empty_i;
    status.overflow  = ovf_q | ovf_pulse_i | rx_lost_i;
    status.underflow = udf_q | udf_pulse_i;
    status.tx_level  = tx_level_i;
    status.rx_level  = rx_level_i;
  end

  // Local read mux and error decode
  always_comb begin
    loc_rdata = '0;
    loc_error = 1'b0;
    if (loc_valid) begin
      case (reg_addr_i)
        spi_host_reg_pkg::CONTROL_OFFSET: loc_rdata = control_q;
        spi_host_reg_pkg::STATUS_OFFSET:  loc_rdata = status;
        // Rejected when disabled or a transfer is running
        spi_host_reg_pkg::COMMAND_OFFSET: loc_error = reg_write_i & ~cmd_ok;
        default:                          loc_error = 1'b1;
      endcase
    end
  end

  assign reg_rdata_o = win_sel ? win_bus.rdata : loc_rdata;
  assign reg_error_o = win_sel ? win_bus.error : loc_error;
  assign clkdiv_o    = control_q.clkdiv;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      control_q   <= '0;
      cmd_valid_o <= 1'b0;
      ovf_q       <= 1'b0;
      udf_q       <= 1'b0;
    end else begin
      cmd_valid_o <= cmd_we & cmd_ok;
      // Reserved bits stay zero
      if (ctrl_we) begin
        control_q.enable <= reg_wdata_i[0];
        control_q.clkdiv <= reg_wdata_i[8:1];
      end
      // New events win over a clear in the same cycle
      if (ovf_pulse_i | rx_lost_i) begin
        ovf_q <= 1'b1;
      end else if (stat_we & stat_wr.overflow) begin
        ovf_q <= 1'b0;
      end
      if (udf_pulse_i) begin
        udf_q <= 1'b1;
      end else if (stat_we & stat_wr.underflow) begin
        udf_q <= 1'b0;
      end
    end
  end

  // Command payload, only meaningful alongside cmd_valid_o
  always_ff @(posedge clk_i) begin
    if (cmd_we & cmd_ok) begin
      cmd_o <= cmd_wr;
    end
  end

endmodule

`default_nettype wire

/* design/spi_host_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_host_macros.svh"

module spi_host_top (
  input  wire logic                      clk_i,
  input  wire logic                      rst_n_i,
  input  wire logic [`SPI_HOST_AW-1:0]   reg_addr_i,
  input  wire logic                      reg_write_i,
  input  wire logic [`SPI_HOST_DW-1:0]   reg_wdata_i,
  input  wire logic [`SPI_HOST_DW/8-1:0] reg_wstrb_i,
  input  wire logic                      reg_valid_i,
  output logic [`SPI_HOST_DW-1:0]        reg_rdata_o,
  output logic                           reg_error_o,
  output logic                           spi_sck_o,
  output logic                           spi_cs_n_o,
  output logic                           spi_sdo_o,
  input  wire logic                      spi_sdi_i
);

  logic [7:0]              clkdiv;
  logic                    cmd_valid;
  spi_host_pkg::cmd_t      cmd;
  logic                    busy;
  logic                    rx_lost;
  logic                    ovf_pulse;
  logic                    udf_pulse;
  logic                    tx_push;
  logic                    tx_pop;
  logic                    tx_full;
  logic                    tx_empty;
  logic [`SPI_HOST_DW-1:0] tx_wdata;
  logic [`SPI_HOST_DW-1:0] tx_rdata;
  logic [`SPI_HOST_LW-1:0] tx_level;
  logic                    rx_push;
  logic                    rx_pop;
  logic                    rx_full;
  logic                    rx_empty;
  logic [`SPI_HOST_DW-1:0] rx_wdata;
  logic [`SPI_HOST_DW-1:0] rx_rdata;
  logic [`SPI_HOST_LW-1:0] rx_level;

  // Window region path from regs to the window block
  reg_bus_if win_bus ();

  spi_host_regs u_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_addr_i  (reg_addr_i),
    .reg_write_i (reg_write_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_wstrb_i (reg_wstrb_i),
    .reg_valid_i (reg_valid_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_error_o (reg_error_o),
    .win_bus     (win_bus),
    .clkdiv_o    (clkdiv),
    .cmd_valid_o (cmd_valid),
    .cmd_o       (cmd),
    .busy_i      (busy),
    .rx_lost_i   (rx_lost),
    .ovf_pulse_i (ovf_pulse),
    .udf_pulse_i (udf_pulse),
    .tx_full_i   (tx_full),
    .rx_empty_i  (rx_empty),
    .tx_level_i  (tx_level),
    .rx_level_i  (rx_level)
  );

  spi_host_window u_window (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .win_bus     (win_bus),
    .tx_push_o   (tx_push),
    .tx_data_o   (tx_wdata),
    .tx_full_i   (tx_full),
    .rx_pop_o    (rx_pop),
    .rx_data_i   (rx_rdata),
    .rx_empty_i  (rx_empty),
    .ovf_pulse_o (ovf_pulse),
    .udf_pulse_o (udf_pulse)
  );

  // Software fills, core drains
  spi_host_fifo #(.Depth(`SPI_HOST_TX_DEPTH)) u_tx_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (tx_push),
    .wdata_i (tx_wdata),
    .pop_i   (tx_pop),
    .rdata_o (tx_rdata),
    .full_o  (tx_full),
    .empty_o (tx_empty),
    .level_o (tx_level)
  );

  // Core fills, software drains
  spi_host_fifo #(.Depth(`SPI_HOST_RX_DEPTH)) u_rx_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (rx_push),
    .wdata_i (rx_wdata),
    .pop_i   (rx_pop),
    .rdata_o (rx_rdata),
    .full_o  (rx_full),
    .empty_o (rx_empty),
    .level_o (rx_level)
  );

  spi_host_core u_core (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .clkdiv_i    (clkdiv),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .busy_o      (busy),
    .tx_pop_o    (tx_pop),
    .tx_data_i   (tx_rdata),
    .tx_empty_i  (tx_empty),
    .rx_push_o   (rx_push),
    .rx_data_o   (rx_wdata),
    .rx_full_i   (rx_full),
    .rx_lost_o   (rx_lost),
    .spi_sck_o   (spi_sck_o),
    .spi_cs_n_o  (spi_cs_n_o),
    .spi_sdo_o   (spi_sdo_o),
    .spi_sdi_i   (spi_sdi_i)
  );

endmodule

`default_nettype wire

/* design/spi_host_window.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_host_macros.svh"

module spi_host_window (
  input  wire logic                    clk_i,
  input  wire logic                    rst_n_i,
  reg_bus_if.slave                     win_bus,
  output logic                         tx_push_o,
  output logic [`SPI_HOST_DW-1:0]      tx_data_o,
  input  wire logic                    tx_full_i,
  output logic                         rx_pop_o,
  input  wire logic [`SPI_HOST_DW-1:0] rx_data_i,
  input  wire logic                    rx_empty_i,
  output logic                         ovf_pulse_o,
  output logic                         udf_pulse_o
);

  logic tx_ok;
  logic rx_ok;

  // TXDATA takes full-word writes only
  assign tx_ok = win_bus.valid & win_bus.write & (&win_bus.wstrb) &
                 (win_bus.addr == spi_host_reg_pkg::TXDATA_OFFSET);

  // RXDATA is read only
  assign rx_ok = win_bus.valid & ~win_bus.write &
                 (win_bus.addr == spi_host_reg_pkg::RXDATA_OFFSET);

  assign tx_push_o = tx_ok;
  assign tx_data_o = win_bus.wdata;
  assign rx_pop_o  = rx_ok;

  // Empty FIFO reads back as zero
  assign win_bus.rdata = (rx_ok & ~rx_empty_i) ? rx_data_i : '0;
  assign win_bus.error = win_bus.valid & ~(tx_ok | rx_ok);

  // Dropped accesses reported one cycle later
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ovf_pulse_o <= 1'b0;
      udf_pulse_o <= 1'b0;
    end else begin
      ovf_pulse_o <= tx_ok & tx_full_i;
      udf_pulse_o <= rx_ok & rx_empty_i;
    end
  end

endmodule

`default_nettype wire

/* sim/tb_spi_host.sv */
`timescale 1ns/1ps
`default_nettype none

`include "spi_host_macros.svh"

module tb_spi_host;

  localparam int CLKDIV      = 2;
  // Duplex 3, transmit only 3, drain 4
  localparam int TOTAL_WORDS = 10;
  localparam int WORD_CYCLES = 32 * 2 * (CLKDIV + 1);
  localparam int WDOG_CYCLES = TOTAL_WORDS * WORD_CYCLES + 2000;

  logic                        clk_i;
  logic                        rst_n_i;
  logic [`SPI_HOST_AW-1:0]     reg_addr_i;
  logic                        reg_write_i;
  logic [`SPI_HOST_DW-1:0]     reg_wdata_i;
  logic [`SPI_HOST_DW/8-1:0]   reg_wstrb_i;
  logic                        reg_valid_i;
  logic [`SPI_HOST_DW-1:0]     reg_rdata_o;
  logic                        reg_error_o;
  logic                        spi_sck_o;
  logic                        spi_cs_n_o;
  logic                        spi_sdo;

  int                          err_cnt;
  int                          check_cnt;
  logic [31:0]                 rng_state;
  // Model of the FIFOs and sticky flags
  logic [31:0]                 tx_model_q[$];
  logic [31:0]                 rx_model_q[$];
  logic                        model_ovf;
  logic                        model_udf;
  // Expected and captured serial words
  logic [31:0]                 exp_sdo_q[$];
  logic [31:0]                 sniff_q[$];

  // SDO looped back to SDI
  spi_host_top UUT (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_addr_i  (reg_addr_i),
    .reg_write_i (reg_write_i),
    .reg_wdata_i (reg_wdata_i),
    .reg_wstrb_i (reg_wstrb_i),
    .reg_valid_i (reg_valid_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_error_o (reg_error_o),
    .spi_sck_o   (spi_sck_o),
    .spi_cs_n_o  (spi_cs_n_o),
    .spi_sdo_o   (spi_sdo),
    .spi_sdi_i   (spi_sdo)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // STATUS from model levels and flags, fields packed from bit 0 upward
  function automatic logic [31:0] expected_status(input logic busy);
    logic [31:0] s;
    s       = '0;
    s[0]    = busy;
    s[1]    = (tx_model_q.size() == `SPI_HOST_TX_DEPTH);
    s[2]    = (rx_model_q.size() == 0);
    s[3]    = model_ovf;
    s[4]    = model_udf;
    s[7:5]  = 3'(tx_model_q.size());
    s[10:8] = 3'(rx_model_q.size());
    return s;
  endfunction

  // Words on the wire and into RX for one command
  function automatic void predict_transfer(input logic tx_only, input int words);
    logic [31:0] w;
    for (int i = 0; i < words; i++) begin
      // Empty TX FIFO sends zeros
      w = '0;
      if (tx_model_q.size() > 0) begin
        w = tx_model_q.pop_front();
      end
      exp_sdo_q.push_back(w);
      // Loopback returns the sent word, lost when RX is full
      if (!tx_only) begin
        if (rx_model_q.size() < `SPI_HOST_RX_DEPTH) begin
          rx_model_q.push_back(w);
        end else begin
          model_ovf = 1'b1;
        end
      end
    end
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    check_cnt++;
    if (got !== exp) begin
      $display("[FAIL] %s: expected %h, got %h", name, exp, got);
      err_cnt++;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk_i);
    #2;
  endtask

  // One bus cycle, entered and left 2 ns after a rising edge
  task automatic bus_access(input logic [4:0] addr, input logic wr, input logic [31:0] wdata,
                            input logic [3:0] strb, output logic [31:0] rdata,
                            output logic err);
    reg_addr_i  = addr;
    reg_write_i = wr;
    reg_wdata_i = wdata;
    reg_wstrb_i = strb;
    reg_valid_i = 1'b1;
    // Response settled by mid cycle
    @(negedge clk_i);
    rdata = reg_rdata_o;
    err   = reg_error_o;
    @(posedge clk_i);
    #2;
    reg_valid_i = 1'b0;
    reg_write_i = 1'b0;
    reg_wstrb_i = '0;
  endtask

  task automatic bus_write(input logic [4:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic exp_err);
    logic [31:0] rd;
    logic        err;
    bus_access(addr, 1'b1, data, strb, rd, err);
    check_value($sformatf("reg_error_o write @%h", addr), 32'(exp_err), 32'(err));
  endtask

  task automatic bus_read(input logic [4:0] addr, input logic exp_err, output logic [31:0] data);
    logic err;
    bus_access(addr, 1'b0, '0, 4'h0, data, err);
    check_value($sformatf("reg_error_o read @%h", addr), 32'(exp_err), 32'(err));
  endtask

  task automatic check_status(input logic busy);
    logic [31:0] st;
    bus_read(spi_host_reg_pkg::STATUS_OFFSET, 1'b0, st);
    check_value("reg_rdata_o STATUS", expected_status(busy), st);
  endtask

  task automatic push_tx(input logic [31:0] word);
    bus_write(spi_host_reg_pkg::TXDATA_OFFSET, word, 4'hF, 1'b0);
    // Full FIFO drops the word
    if (tx_model_q.size() < `SPI_HOST_TX_DEPTH) begin
      tx_model_q.push_back(word);
    end else begin
      model_ovf = 1'b1;
    end
  endtask

  task automatic pop_rx();
    logic [31:0] rd;
    logic [31:0] exp;
    bus_read(spi_host_reg_pkg::RXDATA_OFFSET, 1'b0, rd);
    exp = '0;
    if (rx_model_q.size() > 0) begin
      exp = rx_model_q.pop_front();
    end else begin
      model_udf = 1'b1;
    end
    check_value("reg_rdata_o RXDATA", exp, rd);
  endtask

  // Issue a command and poll busy until it falls
  task automatic run_command(input logic tx_only, input int words);
    spi_host_pkg::cmd_t cmd;
    logic [31:0]        st;
    int                 polls;
    cmd.dir = tx_only ? spi_host_pkg::DIR_TX_ONLY : spi_host_pkg::DIR_DUPLEX;
    cmd.len = 8'(words - 1);
    bus_write(spi_host_reg_pkg::COMMAND_OFFSET, 32'(cmd), 4'hF, 1'b0);
    predict_transfer(tx_only, words);
    // Busy starts one edge after the start pulse
    idle(1);
    polls = 0;
    do begin
      bus_read(spi_host_reg_pkg::STATUS_OFFSET, 1'b0, st);
      if (polls == 0) begin
        check_value("STATUS.busy after command", 32'd1, 32'(st[0]));
      end
      if (tx_only) begin
        check_value("STATUS.rx_level", 32'd0, 32'(st[10:8]));
      end
      polls++;
    end while (st[0] && (polls < words * WORD_CYCLES + 100));
    if (st[0]) begin
      $display("Transfer did not finish, busy still set after %0d polls", polls);
      err_cnt++;
    end
    check_value("spi_cs_n_o after transfer", 32'd1, 32'(spi_cs_n_o));
    idle(2);
    if (exp_sdo_q.size() != 0) begin
      $display("Serial words missing, %0d expected words never seen", exp_sdo_q.size());
      err_cnt++;
      exp_sdo_q.delete();
    end
  endtask

  // Sniffer, mode 0 data valid at rising SCK
  initial begin
    logic [31:0] shift;
    int          nbits;
    shift = '0;
    nbits = 0;
    forever begin
      @(posedge spi_sck_o);
      if (!spi_cs_n_o) begin
        shift = {shift[30:0], spi_sdo};
        nbits++;
        if (nbits == 32) begin
          sniff_q.push_back(shift);
          nbits = 0;
        end
      end
    end
  end

  // Compare captured words with the prediction
  initial begin
    logic [31:0] got;
    logic [31:0] exp;
    forever begin
      @(posedge clk_i);
      while (sniff_q.size() > 0) begin
        got = sniff_q.pop_front();
        if (exp_sdo_q.size() == 0) begin
          $display("Unexpected serial word %h on spi_sdo_o", got);
          err_cnt++;
        end else begin
          exp = exp_sdo_q.pop_front();
          check_value("spi_sdo_o word", exp, got);
        end
      end
    end
  end

  // Watchdog sized from total transfer length
  initial begin
    repeat (WDOG_CYCLES) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles", WDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    rng_state   = 32'h4922;
    err_cnt     = 0;
    check_cnt   = 0;
    model_ovf   = 1'b0;
    model_udf   = 1'b0;
    rst_n_i     = 1'b0;
    reg_addr_i  = '0;
    reg_write_i = 1'b0;
    reg_wdata_i = '0;
    reg_wstrb_i = '0;
    reg_valid_i = 1'b0;
    repeat (10) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    idle(1);

    // Reset state
    check_value("spi_cs_n_o", 32'd1, 32'(spi_cs_n_o));
    check_value("spi_sck_o", 32'd0, 32'(spi_sck_o));
    check_status(1'b0);

    // CONTROL readback, command rejected while disabled
    bus_write(spi_host_reg_pkg::CONTROL_OFFSET, 32'h0000_01FE, 4'hF, 1'b0);
    bus_read(spi_host_reg_pkg::CONTROL_OFFSET, 1'b0, rd);
    check_value("reg_rdata_o CONTROL", 32'h0000_01FE, rd);
    bus_write(spi_host_reg_pkg::COMMAND_OFFSET, 32'h0, 4'hF, 1'b1);
    idle(3);
    check_value("spi_cs_n_o disabled", 32'd1, 32'(spi_cs_n_o));
    check_status(1'b0);
    bus_write(spi_host_reg_pkg::CONTROL_OFFSET, 32'((CLKDIV << 1) | 1), 4'hF, 1'b0);
    bus_read(spi_host_reg_pkg::CONTROL_OFFSET, 1'b0, rd);
    check_value("reg_rdata_o CONTROL", 32'((CLKDIV << 1) | 1), rd);

    // Duplex loopback
    repeat (3) push_tx(next_random());
    run_command(1'b0, 3);
    repeat (3) pop_rx();
    check_status(1'b0);

    // Transmit only, RX level held at zero
    repeat (3) push_tx(next_random());
    run_command(1'b1, 3);
    check_status(1'b0);

    // Sticky overflow and underflow, then write 1 to clear
    repeat (5) push_tx(next_random());
    check_status(1'b0);
    pop_rx();
    check_status(1'b0);
    bus_write(spi_host_reg_pkg::STATUS_OFFSET, 32'h0000_0018, 4'hF, 1'b0);
    model_ovf = 1'b0;
    model_udf = 1'b0;
    check_status(1'b0);
    // Drain the four held words
    run_command(1'b1, 4);
    check_status(1'b0);

    // Window error decode
    bus_read(spi_host_reg_pkg::TXDATA_OFFSET, 1'b1, rd);
    bus_write(spi_host_reg_pkg::RXDATA_OFFSET, next_random(), 4'hF, 1'b1);
    bus_read(5'h18, 1'b1, rd);
    bus_write(5'h18, next_random(), 4'hF, 1'b1);
    bus_write(spi_host_reg_pkg::TXDATA_OFFSET, next_random(), 4'h7, 1'b1);
    push_tx(next_random());
    pop_rx();
    check_status(1'b0);

    idle(2);
    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
